//--- bench/ex_stage_model.svh
`ifndef EX_STAGE_MODEL_SVH
`define EX_STAGE_MODEL_SVH

// What the stage presents for one valid instruction
typedef struct packed {
    logic [XLEN-1:0]      result;           // ALU result, address or link address
    logic [XLEN-1:0]      store_data;
    logic [REG_IDX_W-1:0] reg_dest;
    logic                 reg_write;
    logic                 mem_write;
    logic                 mem_read;
    logic                 mem_to_reg;
    logic                 redirect;
    logic [XLEN-1:0]      redirect_target;
} expect_t;

// Xorshift generator using the 13, 17, 5 shift triple
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Expected stage outputs taken straight from the RV32I rules for each class
function automatic expect_t expected_outputs(
    input alu_op_t              op,
    input alu_ctrl_t            fn,
    input branch_op_t           br,
    input logic                 use_imm,
    input logic [XLEN-1:0]      rs1,
    input logic [XLEN-1:0]      rs2,
    input logic [XLEN-1:0]      imm,
    input logic [XLEN-1:0]      pc,
    input logic                 mem_write,
    input logic                 mem_read,
    input logic                 reg_write,
    input logic                 mem_to_reg,
    input logic [REG_IDX_W-1:0] rd
);
    expect_t         e;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] jump_sum;
    logic            taken;
    case (op)
        ALU_MEM:    begin a = rs1; b = imm; end  // Base plus offset
        ALU_BRANCH: begin a = rs1; b = rs2; end
        ALU_LUI:    begin a = '0;  b = imm; end
        ALU_AUIPC:  begin a = pc;  b = imm; end
        ALU_JAL,
        ALU_JALR:   begin a = pc;  b = LINK_OFFSET; end  // Link address
        default:    begin a = rs1; b = use_imm ? imm : rs2; end
    endcase
    case (fn)
        ALU_ADD:  e.result = a + b;
        ALU_SUB:  e.result = a - b;
        ALU_SLL:  e.result = a << b[SHAMT_W-1:0];
        ALU_SLT:  e.result = ($signed(a) < $signed(b)) ? 1 : 0;
        ALU_SLTU: e.result = (a < b) ? 1 : 0;
        ALU_XOR:  e.result = a ^ b;
        ALU_SRL:  e.result = a >> b[SHAMT_W-1:0];
        ALU_SRA:  e.result = $unsigned($signed(a) >>> b[SHAMT_W-1:0]);
        ALU_OR:   e.result = a | b;
        default:  e.result = a & b;
    endcase
    // True comparisons hold here because the stimulus keeps signed pairs free of overflow
    case (br)
        BR_EQ:   taken = (rs1 == rs2);
        BR_NE:   taken = (rs1 != rs2);
        BR_LT:   taken = ($signed(rs1) < $signed(rs2));
        BR_GE:   taken = ($signed(rs1) >= $signed(rs2));
        BR_LTU:  taken = (rs1 < rs2);
        default: taken = (rs1 >= rs2);
    endcase
    e.redirect = (op == ALU_JAL) || (op == ALU_JALR) || ((op == ALU_BRANCH) && taken);
    jump_sum = rs1 + imm;
    e.redirect_target = (op == ALU_JALR) ? {jump_sum[XLEN-1:1], 1'b0} : pc + imm;
    e.store_data = rs2;
    e.reg_dest   = rd;
    e.reg_write  = reg_write;
    e.mem_write  = mem_write;
    e.mem_read   = mem_read;
    e.mem_to_reg = mem_to_reg;
    return e;
endfunction

`endif

//--- bench/ex_stage_tb.sv
module ex_stage_tb
    import isa_pkg::*, pipe_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    `include "ex_stage_model.svh"

    localparam int          NUM_INSTR   = 2000;
    localparam int          CYCLE_LIMIT = 16 + NUM_INSTR * 2 + 50;
    localparam logic [31:0] SEED        = 32'd24200;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    logic [XLEN-1:0]      rs1_value, rs2_value, imm, pc;
    logic                 alu_src;
    alu_op_t              alu_op;
    alu_ctrl_t            alu_ctrl;
    branch_op_t           branch_op;
    logic                 in_mem_write, in_mem_read, in_reg_write, in_mem_to_reg;
    logic [REG_IDX_W-1:0] in_reg_dest;
    logic                 out_valid;
    logic [XLEN-1:0]      result, store_data, redirect_target;
    logic [REG_IDX_W-1:0] out_reg_dest;
    logic                 out_reg_write, out_mem_write, out_mem_read, out_mem_to_reg;
    logic                 redirect;

    expect_t     exp_q[$];   // One entry per valid instruction, oldest first
    logic [31:0] rng_state;

    ex_stage i_ex_stage (
        .clk(clk), .rst(rst), .in_valid(in_valid),
        .rs1_value(rs1_value), .rs2_value(rs2_value), .imm(imm), .pc(pc),
        .alu_src(alu_src), .alu_op(alu_op), .alu_ctrl(alu_ctrl), .branch_op(branch_op),
        .in_mem_write(in_mem_write), .in_mem_read(in_mem_read),
        .in_reg_write(in_reg_write), .in_mem_to_reg(in_mem_to_reg),
        .in_reg_dest(in_reg_dest),
        .out_valid(out_valid), .result(result), .store_data(store_data),
        .out_reg_dest(out_reg_dest), .out_reg_write(out_reg_write),
        .out_mem_write(out_mem_write), .out_mem_read(out_mem_read),
        .out_mem_to_reg(out_mem_to_reg),
        .redirect(redirect), .redirect_target(redirect_target)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_word(input string field, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] want);
        if (got !== want)
        begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, field, got, want);
            $display("=== FAIL ===");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_flag(input string field, input logic got, input logic want);
        if (got !== want)
        begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, field, got, want);
            $display("=== FAIL ===");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_reg(input string field, input logic [REG_IDX_W-1:0] got,
                             input logic [REG_IDX_W-1:0] want);
        if (got !== want)
        begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, field, got, want);
            $display("=== FAIL ===");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Bubble with random payload and live-looking controls, all of which must be dropped
    task automatic drive_bubble();
        logic [31:0] r;
        r = next_rand();
        in_valid      = 1'b0;
        rs1_value     = next_rand();
        rs2_value     = next_rand();
        imm           = next_rand();
        pc            = next_rand();
        alu_src       = r[0];
        alu_op        = r[1] ? ALU_JAL : ALU_BRANCH;  // Would redirect if not bubbled
        alu_ctrl      = alu_ctrl_t'(5'(r[15:8] % 10));
        branch_op     = r[2] ? BR_NE : BR_EQ;
        in_mem_write  = r[3];
        in_mem_read   = r[4];
        in_reg_write  = r[5];
        in_mem_to_reg = r[6];
        in_reg_dest   = r[20:16];
    endtask

    task automatic drive_instruction();
        logic [31:0] pick;
        logic [31:0] r1;
        logic [31:0] r2;
        pick = next_rand();
        r1   = next_rand();
        r2   = next_rand();
        in_valid      = 1'b1;
        rs1_value     = next_rand();
        rs2_value     = next_rand();
        imm           = {{20{r1[11]}}, r1[11:0]};  // Sign extended 12-bit immediate
        pc            = {r2[31:2], 2'b00};
        alu_src       = r1[12];
        alu_op        = ALU_REG;
        alu_ctrl      = ALU_ADD;
        branch_op     = BR_EQ;
        in_mem_write  = 1'b0;
        in_mem_read   = 1'b0;
        in_reg_write  = 1'b1;
        in_mem_to_reg = 1'b0;
        in_reg_dest   = r1[17:13];
        case (pick % 8)
            0, 1:
                alu_ctrl = alu_ctrl_t'(5'(pick[23:8] % 10));  // All ten functions
            2:
            begin
                alu_op = ALU_MEM;
                if (pick[8])
                begin
                    in_mem_read   = 1'b1;  // Load writes rd from memory
                    in_mem_to_reg = 1'b1;
                end
                else
                begin
                    in_mem_write = 1'b1;
                    in_reg_write = 1'b0;
                end
            end
            3, 4:
            begin
                alu_op       = ALU_BRANCH;
                alu_ctrl     = ALU_SUB;
                in_reg_write = 1'b0;
                case (pick[23:8] % 6)
                    0:       branch_op = BR_EQ;
                    1:       branch_op = BR_NE;
                    2:       branch_op = BR_LT;
                    3:       branch_op = BR_GE;
                    4:       branch_op = BR_LTU;
                    default: branch_op = BR_GEU;
                endcase
                if (pick[24])
                    rs2_value = rs1_value;  // Equal pair half of the time
                if (branch_op == BR_LT || branch_op == BR_GE)
                begin
                    // Halving keeps rs1 minus rs2 inside the signed range
                    rs1_value = $unsigned($signed(rs1_value) >>> 1);
                    rs2_value = $unsigned($signed(rs2_value) >>> 1);
                end
            end
            5:
            begin
                alu_op = pick[8] ? ALU_LUI : ALU_AUIPC;
                imm    = {r1[31:12], 12'h000};
            end
            6:
            begin
                alu_op = ALU_JAL;
                imm    = {{11{r1[20]}}, r1[20:1], 1'b0};  // J-type offset
            end
            default:
                alu_op = ALU_JALR;  // rs1 keeps a random bit 0 to test the clearing
        endcase
        exp_q.push_back(expected_outputs(alu_op, alu_ctrl, branch_op, alu_src,
                                         rs1_value, rs2_value, imm, pc,
                                         in_mem_write, in_mem_read, in_reg_write,
                                         in_mem_to_reg, in_reg_dest));
    endtask

    initial
    begin : stimulus
        int sent;
        sent      = 0;
        rng_state = SEED;
        rst       = 1'b1;
        in_valid      = 1'b0;
        rs1_value     = '0;
        rs2_value     = '0;
        imm           = '0;
        pc            = '0;
        alu_src       = 1'b0;
        alu_op        = ALU_REG;
        alu_ctrl      = ALU_ADD;
        branch_op     = BR_EQ;
        in_mem_write  = 1'b0;
        in_mem_read   = 1'b0;
        in_reg_write  = 1'b0;
        in_mem_to_reg = 1'b0;
        in_reg_dest   = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        while (sent < NUM_INSTR)
        begin
            @(negedge clk);
            if (next_rand() % 4 != 0)  // About three valid cycles in four
            begin
                drive_instruction();
                sent++;
            end
            else
                drive_bubble();
        end
        @(negedge clk);
        drive_bubble();
        while (exp_q.size() != 0)
            @(negedge clk);  // Drained once the compare process has seen every result
        $display("=== PASS ===");
        $finish;
    end

    // Reads at the rising edge see what the previous edge registered
    initial
    begin : compare
        logic [1:0] valid_hist;  // in_valid at the last two edges, newest in bit 0
        expect_t    want;
        valid_hist = '0;
        @(posedge clk);  // First edge applies reset
        forever
        begin
            @(posedge clk);
            // Registered at the last edge, one edge after the ID/EX latch took its instruction
            check_flag("out_valid", out_valid, valid_hist[1]);
            if (out_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("Output marked valid at %0t ns with no instruction pending", $time);
                    $display("=== FAIL ===");
                    $fatal(1, "Unexpected valid output");
                end
                want = exp_q.pop_front();
                check_word("result", result, want.result);
                check_word("store_data", store_data, want.store_data);
                check_reg("out_reg_dest", out_reg_dest, want.reg_dest);
                check_flag("out_reg_write", out_reg_write, want.reg_write);
                check_flag("out_mem_write", out_mem_write, want.mem_write);
                check_flag("out_mem_read", out_mem_read, want.mem_read);
                check_flag("out_mem_to_reg", out_mem_to_reg, want.mem_to_reg);
                check_flag("redirect", redirect, want.redirect);
                check_word("redirect_target", redirect_target, want.redirect_target);
            end
            else
            begin
                check_flag("redirect", redirect, 1'b0);  // Bubbles carry no controls
                check_flag("out_reg_write", out_reg_write, 1'b0);
                check_flag("out_mem_write", out_mem_write, 1'b0);
                check_flag("out_mem_read", out_mem_read, 1'b0);
                check_flag("out_mem_to_reg", out_mem_to_reg, 1'b0);
            end
            valid_hist = {valid_hist[0], in_valid & ~rst};
        end
    end

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Run timed out after %0d cycles before all results arrived", cycles);
        $display("=== FAIL ===");
        $fatal(1, "Timeout");
    end

endmodule

//--- rv32_execute.f
+incdir+bench
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/alu.sv
verilog/operand_select.sv
verilog/branch_resolve.sv
verilog/execute.sv
verilog/ex_mem_register.sv
verilog/ex_stage.sv
bench/ex_stage_tb.sv

//--- verilog/alu.sv
module alu
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic [XLEN-1:0] a,         // First operand, usually rs1 or pc
    input  logic [XLEN-1:0] b,         // Second operand, rs2, imm or link offset
    input  alu_ctrl_t       alu_ctrl,  // Function select from the decoder
    output logic [XLEN-1:0] result,
    output logic            zero,      // Result is all zeros
    output logic            borrow     // Unsigned borrow out of a minus b
);

    logic [XLEN:0]      diff;       // Extra top bit catches the unsigned borrow
    logic [SHAMT_W-1:0] shamt;      // Shift amount from the low bits of b
    logic               lt_signed;  // Signed compare for SLT

    // One subtractor serves SUB, SLTU and the borrow flag
    assign diff = {1'b0, a} - {1'b0, b};

    assign shamt = b[SHAMT_W-1:0];  // Upper bits of b are ignored for shifts

    assign lt_signed = $signed(a) < $signed(b);

    always_comb
    begin
        case (alu_ctrl)
            ALU_ADD:
                result = a + b;
            ALU_SUB:
                result = diff[XLEN-1:0];
            ALU_SLL:
                result = a << shamt;
            ALU_SLT:
                result = {{(XLEN-1){1'b0}}, lt_signed};  // Zero extended compare bit
            ALU_SLTU:
                result = {{(XLEN-1){1'b0}}, diff[XLEN]};  // Borrow means a below b
            ALU_XOR:
                result = a ^ b;
            ALU_SRL:
                result = a >> shamt;  // Logical, fills with zeros
            ALU_SRA:
                result = $unsigned($signed(a) >>> shamt);  // Arithmetic, copies the sign
            ALU_OR:
                result = a | b;
            ALU_AND:
                result = a & b;
            default:
                result = '0;  // Unused encodings give a quiet zero
        endcase
    end

    // Flags for branch resolution
    // Zero follows the selected function, borrow always comes from the subtractor
    assign zero   = (result == '0);
    assign borrow = diff[XLEN];

endmodule

//--- verilog/branch_resolve.sv
module branch_resolve
    import isa_pkg::*, pipe_pkg::*;
(
    input  alu_op_t         alu_op,
    input  branch_op_t      branch_op,
    input  alu_ctrl_t       alu_ctrl,        // Only checked, never steers the logic
    input  logic            zero,            // ALU flags from rs1 minus rs2
    input  logic            borrow,
    input  logic            sign,            // Top bit of the ALU result
    input  logic [XLEN-1:0] rs1_value,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] pc,
    output logic            redirect,        // Fetch must restart at redirect_target
    output logic [XLEN-1:0] redirect_target
);

    logic            cond_true;  // The selected branch condition holds
    logic [XLEN-1:0] jalr_sum;   // rs1 plus imm before the low bit is cleared

    // Signed conditions use the sign of the difference, which is wrong on overflow
    always_comb
    begin
        case (branch_op)
            BR_EQ:   cond_true = zero;
            BR_NE:   cond_true = !zero;
            BR_LT:   cond_true = sign;
            BR_GE:   cond_true = !sign;
            BR_LTU:  cond_true = borrow;
            BR_GEU:  cond_true = !borrow;
            default: cond_true = 1'b0;  // Reserved funct3 values never branch
        endcase
    end

    always_comb
    begin
        case (alu_op)
            ALU_JAL, ALU_JALR: redirect = 1'b1;       // Jumps always leave the sequence
            ALU_BRANCH:        redirect = cond_true;
            default:           redirect = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_value + imm;

    // JALR clears bit 0 of its target, everything else is pc relative
    assign redirect_target = (alu_op == ALU_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc + imm;

    // The flags above only mean something when the ALU subtracted
    always_comb
    begin
        if (alu_op == ALU_BRANCH)
        begin
            assert final (alu_ctrl == ALU_SUB)
            else $error("Branch issued with an ALU function other than SUB");
        end
    end

endmodule

//--- verilog/ex_mem_register.sv
module ex_mem_register
    import pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid,
    input  logic [XLEN-1:0]      result,
    input  logic [XLEN-1:0]      store_data,
    input  logic [REG_IDX_W-1:0] reg_dest,
    input  logic                 reg_write,
    input  logic                 mem_write,
    input  logic                 mem_read,
    input  logic                 mem_to_reg,
    input  logic                 redirect,
    input  logic [XLEN-1:0]      redirect_target,
    output logic                 out_valid,
    output logic [XLEN-1:0]      out_result,      // Memory address or write-back value
    output logic [XLEN-1:0]      out_store_data,
    output logic [REG_IDX_W-1:0] out_reg_dest,
    output logic                 out_reg_write,
    output logic                 out_mem_write,
    output logic                 out_mem_read,
    output logic                 out_mem_to_reg,
    output logic                 out_redirect,
    output logic [XLEN-1:0]      out_redirect_target
);

    // Controls come out of reset inactive so memory and write-back see bubbles
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            out_valid      <= 1'b0;
            out_reg_write  <= 1'b0;
            out_mem_write  <= 1'b0;
            out_mem_read   <= 1'b0;
            out_mem_to_reg <= 1'b0;
            out_redirect   <= 1'b0;
        end
        else
        begin
            out_valid      <= valid;
            out_reg_write  <= reg_write;
            out_mem_write  <= mem_write;
            out_mem_read   <= mem_read;
            out_mem_to_reg <= mem_to_reg;
            out_redirect   <= redirect;
        end
    end

    always_ff @(posedge clk)
    begin
        out_result          <= result;
        out_store_data      <= store_data;
        out_reg_dest        <= reg_dest;
        out_redirect_target <= redirect_target;  // Only meaningful with out_redirect
    end

    // The bubble class from the ID/EX latch must keep redirect quiet
    assert property (@(posedge clk) disable iff (rst) redirect |-> valid)
    else $error("Redirect raised by a bubble");

endmodule

//--- verilog/ex_stage.sv
module ex_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic [XLEN-1:0]      rs1_value,
    input  logic [XLEN-1:0]      rs2_value,
    input  logic [XLEN-1:0]      imm,
    input  logic [XLEN-1:0]      pc,
    input  logic                 alu_src,
    input  alu_op_t              alu_op,
    input  alu_ctrl_t            alu_ctrl,
    input  branch_op_t           branch_op,
    input  logic                 in_mem_write,
    input  logic                 in_mem_read,
    input  logic                 in_reg_write,
    input  logic                 in_mem_to_reg,
    input  logic [REG_IDX_W-1:0] in_reg_dest,
    output logic                 out_valid,       // Two cycles after in_valid
    output logic [XLEN-1:0]      result,
    output logic [XLEN-1:0]      store_data,
    output logic [REG_IDX_W-1:0] out_reg_dest,
    output logic                 out_reg_write,
    output logic                 out_mem_write,
    output logic                 out_mem_read,
    output logic                 out_mem_to_reg,
    output logic                 redirect,
    output logic [XLEN-1:0]      redirect_target
);

    // Execute outputs during the cycle after the ID/EX latch
    logic                 ex_valid;
    logic [XLEN-1:0]      ex_result, ex_store_data, ex_redirect_target;
    logic [REG_IDX_W-1:0] ex_reg_dest;
    logic                 ex_reg_write, ex_mem_write, ex_mem_read, ex_mem_to_reg;
    logic                 ex_redirect;

    execute i_execute (
        .clk(clk), .rst(rst), .in_valid(in_valid),
        .rs1_value(rs1_value), .rs2_value(rs2_value), .imm(imm), .pc(pc),
        .alu_src(alu_src), .alu_op(alu_op), .alu_ctrl(alu_ctrl), .branch_op(branch_op),
        .in_mem_write(in_mem_write), .in_mem_read(in_mem_read),
        .in_reg_write(in_reg_write), .in_mem_to_reg(in_mem_to_reg),
        .in_reg_dest(in_reg_dest),
        .valid(ex_valid), .result(ex_result), .store_data(ex_store_data),
        .reg_dest(ex_reg_dest), .reg_write(ex_reg_write), .mem_write(ex_mem_write),
        .mem_read(ex_mem_read), .mem_to_reg(ex_mem_to_reg),
        .redirect(ex_redirect), .redirect_target(ex_redirect_target)
    );

    ex_mem_register i_ex_mem_register (
        .clk(clk), .rst(rst),
        .valid(ex_valid), .result(ex_result), .store_data(ex_store_data),
        .reg_dest(ex_reg_dest), .reg_write(ex_reg_write), .mem_write(ex_mem_write),
        .mem_read(ex_mem_read), .mem_to_reg(ex_mem_to_reg),
        .redirect(ex_redirect), .redirect_target(ex_redirect_target),
        .out_valid(out_valid), .out_result(result), .out_store_data(store_data),
        .out_reg_dest(out_reg_dest), .out_reg_write(out_reg_write),
        .out_mem_write(out_mem_write), .out_mem_read(out_mem_read),
        .out_mem_to_reg(out_mem_to_reg),
        .out_redirect(redirect), .out_redirect_target(redirect_target)
    );

endmodule

//--- verilog/execute.sv
module execute
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,        // One cycle strobe per instruction
    input  logic [XLEN-1:0]      rs1_value,
    input  logic [XLEN-1:0]      rs2_value,
    input  logic [XLEN-1:0]      imm,
    input  logic [XLEN-1:0]      pc,
    input  logic                 alu_src,
    input  alu_op_t              alu_op,
    input  alu_ctrl_t            alu_ctrl,
    input  branch_op_t           branch_op,
    input  logic                 in_mem_write,
    input  logic                 in_mem_read,
    input  logic                 in_reg_write,
    input  logic                 in_mem_to_reg,
    input  logic [REG_IDX_W-1:0] in_reg_dest,
    output logic                 valid,
    output logic [XLEN-1:0]      result,          // ALU result or link address
    output logic [XLEN-1:0]      store_data,
    output logic [REG_IDX_W-1:0] reg_dest,
    output logic                 reg_write,
    output logic                 mem_write,
    output logic                 mem_read,
    output logic                 mem_to_reg,
    output logic                 redirect,
    output logic [XLEN-1:0]      redirect_target
);

    alu_op_t              alu_op_q;     // Reset and bubbles hold ALU_REG, which never redirects
    logic [XLEN-1:0]      rs1_q, imm_q, pc_q;
    logic                 alu_src_q;
    alu_ctrl_t            alu_ctrl_q;
    branch_op_t           branch_op_q;
    logic [XLEN-1:0]      a, b;         // Selected operands
    logic                 zero, borrow;

    // ID/EX latch, control half
    // A cycle without in_valid loads a bubble with every control cleared
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            valid      <= 1'b0;
            reg_write  <= 1'b0;
            mem_write  <= 1'b0;
            mem_read   <= 1'b0;
            mem_to_reg <= 1'b0;
            alu_op_q   <= ALU_REG;
        end
        else
        begin
            valid      <= in_valid;
            reg_write  <= in_valid & in_reg_write;
            mem_write  <= in_valid & in_mem_write;
            mem_read   <= in_valid & in_mem_read;
            mem_to_reg <= in_valid & in_mem_to_reg;
            alu_op_q   <= in_valid ? alu_op : ALU_REG;
        end
    end

    // Payload half loads every cycle, a bubble's payload is simply ignored downstream
    always_ff @(posedge clk)
    begin
        rs1_q       <= rs1_value;
        store_data  <= rs2_value;  // rs2 doubles as the store data
        imm_q       <= imm;
        pc_q        <= pc;
        alu_src_q   <= alu_src;
        alu_ctrl_q  <= alu_ctrl;
        branch_op_q <= branch_op;
        reg_dest    <= in_reg_dest;
    end

    operand_select i_operand_select (
        .alu_op(alu_op_q), .alu_src(alu_src_q), .rs1_value(rs1_q), .rs2_value(store_data),
        .imm(imm_q), .pc(pc_q), .a(a), .b(b)
    );

    alu i_alu (
        .a(a), .b(b), .alu_ctrl(alu_ctrl_q), .result(result), .zero(zero), .borrow(borrow)
    );

    branch_resolve i_branch_resolve (
        .alu_op(alu_op_q), .branch_op(branch_op_q), .alu_ctrl(alu_ctrl_q),
        .zero(zero), .borrow(borrow), .sign(result[XLEN-1]),  // Sign of rs1 minus rs2
        .rs1_value(rs1_q), .imm(imm_q), .pc(pc_q),
        .redirect(redirect), .redirect_target(redirect_target)
    );

    // A decoder fault would issue a load and a store at once
    assert property (@(posedge clk) disable iff (rst) !(mem_write && mem_read))
    else $error("Instruction latched as both load and store");

endmodule

//--- verilog/isa_pkg.sv
package isa_pkg;

    // Instruction class from the decoder
    // It steers operand selection and redirect resolution
    typedef enum logic [2:0] {
        ALU_MEM    = 3'b000,  // Loads and stores, address is rs1 plus imm
        ALU_BRANCH = 3'b001,  // Conditional branches compare rs1 with rs2
        ALU_REG    = 3'b010,  // Register or immediate arithmetic, also the bubble class
        ALU_JAL    = 3'b011,  // Jump and link relative to pc
        ALU_LUI    = 3'b100,  // Upper immediate goes straight to rd
        ALU_AUIPC  = 3'b101,  // Upper immediate added to pc
        ALU_JALR   = 3'b111   // Jump and link through rs1
    } alu_op_t;

    // Exact function the ALU performs
    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,   // Branches always use this one
        ALU_SLL  = 5'd2,
        ALU_SLT  = 5'd3,
        ALU_SLTU = 5'd4,
        ALU_XOR  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_OR   = 5'd8,
        ALU_AND  = 5'd9
    } alu_ctrl_t;

    // Branch condition, encoded as the funct3 field of the B-type instruction
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_op_t;

endpackage

//--- verilog/operand_select.sv
module operand_select
    import isa_pkg::*, pipe_pkg::*;
(
    input  alu_op_t         alu_op,     // Instruction class
    input  logic            alu_src,    // Immediate instead of rs2 for the register class
    input  logic [XLEN-1:0] rs1_value,
    input  logic [XLEN-1:0] rs2_value,
    input  logic [XLEN-1:0] imm,        // Already sign extended and shifted by the decoder
    input  logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] a,
    output logic [XLEN-1:0] b
);

    always_comb
    begin
        case (alu_op)
            ALU_MEM:
            begin
                a = rs1_value;  // Base register
                b = imm;        // Byte offset, so the ALU forms the address
            end
            ALU_BRANCH:
            begin
                a = rs1_value;  // The ALU subtracts the two registers
                b = rs2_value;  // and the flags decide the branch
            end
            ALU_REG:
            begin
                a = rs1_value;
                b = alu_src ? imm : rs2_value;  // I-type or R-type
            end
            ALU_LUI:
            begin
                a = '0;   // Adding to zero passes the immediate through
                b = imm;
            end
            ALU_AUIPC:
            begin
                a = pc;
                b = imm;
            end
            ALU_JAL, ALU_JALR:
            begin
                // The result of a jump is the link address for rd
                // The target comes from the adder in branch_resolve
                a = pc;
                b = LINK_OFFSET;
            end
            default:
            begin
                a = '0;  // Encoding 3'b110 is not a valid class
                b = '0;
            end
        endcase
    end

endmodule

//--- verilog/pipe_pkg.sv
package pipe_pkg;

    // Width of every register value, immediate and pc in the pipeline
    localparam int XLEN = 32;

    // Register file index width, 32 architectural registers
    localparam int REG_IDX_W = 5;

    // Amount added to pc to form the link address of JAL and JALR
    // It is also the distance between two sequential instructions
    localparam logic [XLEN-1:0] LINK_OFFSET = XLEN'(4);

    // Only the low bits of the second operand count for a shift in RV32I
    localparam int SHAMT_W = 5;

endpackage
